// File: Makefile
# Verilator build and run for alu_cluster.
BIN  := obj_dir/Valu_cluster_tb
SRCS := alu_settings.svh alu_pkg.sv adder.sv alu_req_fifo.sv alu_arbiter.sv \
        sequential_alu.sv alu_cluster.sv alu_cluster_properties.sv alu_cluster_tb.sv

.PHONY: all run clean

all: run

$(BIN): $(SRCS) alu_cluster.f
	verilator --binary --assert --timing -f alu_cluster.f --top-module alu_cluster_tb \
		-Mdir obj_dir -o Valu_cluster_tb

run: $(BIN)
	@out=$$(./$(BIN) +verilator+error+limit+100 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir

// File: adder.sv
`timescale 1ns/1ps

module adder #(
   parameter int DATA_WIDTH = 8
) (
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf
);

   logic sign_a;
   logic sign_b;
   logic sign_q;

   assign o_q    = i_a + i_b;
   assign sign_a = i_a[DATA_WIDTH-1];
   assign sign_b = i_b[DATA_WIDTH-1];
   assign sign_q = o_q[DATA_WIDTH-1];

   // Like signs in, other sign out.
   assign o_ovf  = (sign_a == sign_b) && (sign_q != sign_a);

endmodule

// File: alu_arbiter.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_arbiter (
   input  logic                                         i_clk,
   input  logic                                         i_nrst,
   input  logic                  [`ALU_NUM_CLIENTS-1:0] i_empty,
   input  alu_pkg::alu_req_t     [`ALU_NUM_CLIENTS-1:0] i_head,
   output logic                  [`ALU_NUM_CLIENTS-1:0] o_pop,
   input  logic                                         i_alu_busy,
   input  logic                                         i_alu_done,
   input  alu_pkg::client_id_t                          i_alu_tag,
   output logic                                         o_start,
   output alu_pkg::alu_tag_req_t                        o_cmd,
   output logic                  [`ALU_NUM_CLIENTS-1:0] o_rsp_valid
);

   localparam int N = `ALU_NUM_CLIENTS;

   alu_pkg::client_id_t last_grant;
   alu_pkg::client_id_t grant;
   logic                found;
   logic                launch;

   // ####################
   // Round robin search.
   // ####################
   always_comb begin
      int idx;
      found = 1'b0;
      grant = last_grant;
      for (int i = 1; i <= N; i++) begin
         idx = (int'(last_grant) + i) % N;    // Last served is tried last.
         if (!found && !i_empty[idx]) begin
            found = 1'b1;
            grant = alu_pkg::client_id_t'(idx);
         end
      end
   end

   // o_start doubles as the guard until o_busy rises.
   assign launch = found & ~i_alu_busy & ~o_start;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_start    <= 1'b0;
         o_pop      <= '0;
         last_grant <= alu_pkg::client_id_t'(N - 1);
      end else begin
         o_start <= launch;
         o_pop   <= '0;
         if (launch) begin
            o_pop[grant] <= 1'b1;
            last_grant   <= grant;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (launch)
         o_cmd <= '{req: i_head[grant], id: grant};
   end

   // ####################
   // Result routing.
   // ####################
   always_comb begin
      for (int k = 0; k < N; k++)
         o_rsp_valid[k] = i_alu_done && (i_alu_tag == alu_pkg::client_id_t'(k));
   end

endmodule

// File: alu_cluster.f
+incdir+.
alu_pkg.sv
adder.sv
alu_req_fifo.sv
alu_arbiter.sv
sequential_alu.sv
alu_cluster.sv
alu_cluster_properties.sv
alu_cluster_tb.sv

// File: alu_cluster.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_cluster (
   input  logic                              i_clk,
   input  logic                              i_nrst,
   input  logic              [`ALU_NUM_CLIENTS-1:0] i_req_valid,
   input  alu_pkg::alu_req_t [`ALU_NUM_CLIENTS-1:0] i_req,
   output logic              [`ALU_NUM_CLIENTS-1:0] o_rsp_valid,
   output alu_pkg::alu_rsp_t                        o_rsp
);

   logic                  [`ALU_NUM_CLIENTS-1:0] q_empty;
   logic                  [`ALU_NUM_CLIENTS-1:0] q_full;     // Watched by the checker.
   logic                  [`ALU_NUM_CLIENTS-1:0] q_pop;
   alu_pkg::alu_req_t     [`ALU_NUM_CLIENTS-1:0] q_head;
   logic                                         alu_start;
   logic                                         alu_busy;
   logic                                         alu_done;
   alu_pkg::alu_tag_req_t                        alu_cmd;
   alu_pkg::client_id_t                          alu_tag;

   // ####################
   // Client queues.
   // ####################
   for (genvar k = 0; k < `ALU_NUM_CLIENTS; k++) begin : g_queue
      alu_req_fifo #(
         .T     (alu_pkg::alu_req_t),
         .DEPTH (`ALU_FIFO_DEPTH)
      ) u_queue (
         .i_clk   (i_clk),
         .i_nrst  (i_nrst),
         .i_push  (i_req_valid[k]),
         .i_data  (i_req[k]),
         .i_pop   (q_pop[k]),
         .o_head  (q_head[k]),
         .o_empty (q_empty[k]),
         .o_full  (q_full[k])
      );
   end

   alu_arbiter u_arbiter (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_empty     (q_empty),
      .i_head      (q_head),
      .o_pop       (q_pop),
      .i_alu_busy  (alu_busy),
      .i_alu_done  (alu_done),
      .i_alu_tag   (alu_tag),
      .o_start     (alu_start),
      .o_cmd       (alu_cmd),
      .o_rsp_valid (o_rsp_valid)
   );

   sequential_alu #(
      .DATA_WIDTH (`ALU_DATA_WIDTH)
   ) u_alu (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (alu_start),
      .i_cmd   (alu_cmd),
      .o_busy  (alu_busy),
      .o_done  (alu_done),
      .o_rsp   (o_rsp),
      .o_tag   (alu_tag)
   );

endmodule

// File: alu_cluster_properties.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_cluster_properties (
   input logic                                     i_clk,
   input logic                                     i_nrst,
   input logic              [`ALU_NUM_CLIENTS-1:0] i_req_valid,
   input alu_pkg::alu_req_t [`ALU_NUM_CLIENTS-1:0] i_req,
   input logic              [`ALU_NUM_CLIENTS-1:0] i_rsp_valid,
   input alu_pkg::alu_rsp_t                        i_rsp,
   input logic              [`ALU_NUM_CLIENTS-1:0] i_q_full
);

   localparam int N       = `ALU_NUM_CLIENTS;
   localparam int W       = `ALU_DATA_WIDTH;
   localparam int MAX_VAL = 2 ** (W - 1) - 1;
   localparam int MIN_VAL = -(2 ** (W - 1));
   localparam int MAX_LAT = 3 * W + 3 + 2;                 // Divide bound plus launch.
   localparam int BOUND   = 2 * MAX_LAT * `ALU_FIFO_DEPTH;

   alu_pkg::alu_rsp_t exp_mem [N][8];
   alu_pkg::alu_rsp_t exp_head [N];
   logic [2:0]        wr_ptr [N];
   logic [2:0]        rd_ptr [N];
   int unsigned       wait_cnt [N];
   logic              seen_req;
   int unsigned       err_count = 0;

   function automatic alu_pkg::alu_rsp_t expect_rsp(input alu_pkg::alu_req_t req);
      int                a;
      int                b;
      int                full;
      alu_pkg::alu_rsp_t rsp;
      a = int'($signed(req.a));
      b = int'($signed(req.b));
      case (req.op)
         alu_pkg::OP_ADD: full = a + b;
         alu_pkg::OP_SUB: full = a - b;
         alu_pkg::OP_MUL: full = a * b;                    // Low half kept below.
         default:         full = (b == 0) ? 0 : a / b;     // Truncates toward zero.
      endcase
      rsp.q    = full[W-1:0];
      rsp.ovf  = (req.op == alu_pkg::OP_ADD || req.op == alu_pkg::OP_SUB) &&
                 (full > MAX_VAL || full < MIN_VAL);
      rsp.zero = (req.op == alu_pkg::OP_DIV) && (b == 0);
      return rsp;
   endfunction

   // ####################
   // Reference model.
   // ####################
   always @(posedge i_clk) begin
      for (int k = 0; k < N; k++)
         if (i_req_valid[k])
            exp_mem[k][wr_ptr[k]] <= expect_rsp(i_req[k]);
   end

   always_comb begin
      for (int k = 0; k < N; k++)
         exp_head[k] = exp_mem[k][rd_ptr[k]];
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         seen_req <= 1'b0;
         for (int k = 0; k < N; k++) begin
            wr_ptr[k]   <= '0;
            rd_ptr[k]   <= '0;
            wait_cnt[k] <= 0;
         end
      end else begin
         if (i_req_valid != '0)
            seen_req <= 1'b1;
         for (int k = 0; k < N; k++) begin
            if (i_req_valid[k])
               wr_ptr[k] <= wr_ptr[k] + 3'd1;
            if (i_rsp_valid[k])
               rd_ptr[k] <= rd_ptr[k] + 3'd1;
            if (i_rsp_valid[k] || wr_ptr[k] == rd_ptr[k])
               wait_cnt[k] <= 0;                           // Served or nothing pending.
            else
               wait_cnt[k] <= wait_cnt[k] + 1;
         end
      end
   end

   // ####################
   // Assertions.
   // ####################
   a_quiet: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !seen_req |-> i_rsp_valid == '0)
      else begin
         err_count++;
         $error("response strobe before any request at %0t", $time);
      end

   a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $onehot0(i_rsp_valid))
      else begin
         err_count++;
         $error("two response strobes in one cycle at %0t", $time);
      end

   for (genvar k = 0; k < N; k++) begin : g_client
      a_expected: assert property (@(posedge i_clk) disable iff (!i_nrst)
         i_rsp_valid[k] |-> wr_ptr[k] != rd_ptr[k])
         else begin
            err_count++;
            $error("client %0d got a response with nothing outstanding at %0t", k, $time);
         end

      a_value: assert property (@(posedge i_clk) disable iff (!i_nrst)
         i_rsp_valid[k] && wr_ptr[k] != rd_ptr[k] |-> i_rsp == exp_head[k])
         else begin
            err_count++;
            $error("MISMATCH time %0t o_rsp client %0d got %h expected %h",
                   $time, k, $sampled(i_rsp), $sampled(exp_head[k]));
         end

      a_no_overrun: assert property (@(posedge i_clk) disable iff (!i_nrst)
         i_req_valid[k] |-> !i_q_full[k])
         else begin
            err_count++;
            $error("client %0d pushed into a full queue at %0t", k, $time);
         end

      a_fair: assert property (@(posedge i_clk) disable iff (!i_nrst)
         wait_cnt[k] < BOUND)
         else begin
            err_count++;
            $error("client %0d waited over %0d cycles for a response", k, BOUND);
         end
   end

endmodule

// File: alu_cluster_tb.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_cluster_tb;

   localparam int N           = `ALU_NUM_CLIENTS;
   localparam int W           = `ALU_DATA_WIDTH;
   localparam int DEPTH       = `ALU_FIFO_DEPTH;
   localparam int MAX_S       = 2 ** (W - 1) - 1;
   localparam int MIN_S       = -(2 ** (W - 1));
   localparam int NUM_REQS    = 400;
   localparam int STIM_LIMIT  = 60000;                     // Cycles.
   localparam int DRAIN_LIMIT = 2000;

   logic                      i_clk;
   logic                      i_nrst;
   logic              [N-1:0] i_req_valid;
   alu_pkg::alu_req_t [N-1:0] i_req;
   logic              [N-1:0] o_rsp_valid;
   alu_pkg::alu_rsp_t         o_rsp;
   logic [31:0]               rng_state;
   int                        outstanding [N];
   alu_pkg::alu_req_t         directed [$];

   alu_cluster dut (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_req_valid (i_req_valid),
      .i_req       (i_req),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp)
   );

   bind alu_cluster alu_cluster_properties u_props (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_req_valid (i_req_valid),
      .i_req       (i_req),
      .i_rsp_valid (o_rsp_valid),
      .i_rsp       (o_rsp),
      .i_q_full    (q_full)
   );

   always #50 i_clk = ~i_clk;

   // ####################
   // Helpers.
   // ####################
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic bit clients_idle();
      bit idle;
      idle = (i_req_valid == '0);
      for (int k = 0; k < N; k++)
         if (outstanding[k] != 0)
            idle = 1'b0;
      return idle;
   endfunction

   task automatic stop_on_failure(input string reason);
      $display("Test failed");
      $fatal(1, "%s", reason);
   endtask

   task automatic add_directed(input alu_pkg::alu_op_e op, input logic [W-1:0] a,
                               input logic [W-1:0] b);
      directed.push_back('{op: op, a: a, b: b});
   endtask

   task automatic next_request(output alu_pkg::alu_req_t req);
      logic [31:0] ra;
      logic [31:0] rb;
      if (directed.size() != 0) begin
         req = directed.pop_front();
      end else begin
         rng_state = xorshift32(rng_state);
         ra        = rng_state;
         rng_state = xorshift32(rng_state);
         rb        = rng_state;
         req.op    = alu_pkg::alu_op_e'(ra[31:30]);
         req.a     = ra[W-1:0];
         req.b     = rb[W-1:0];
         if (rb[31:28] == 4'd0)
            req.b = '0;                                    // Some divides by zero.
         else if (rb[27])
            req.b = W'($signed(rb[3:0]));                  // Small divisors.
      end
   endtask

   // Requests in flight per client, seen at the ports.
   always @(posedge i_clk or negedge i_nrst) begin
      for (int k = 0; k < N; k++)
         if (!i_nrst)
            outstanding[k] <= 0;
         else
            outstanding[k] <= outstanding[k] + int'(i_req_valid[k]) - int'(o_rsp_valid[k]);
   end

   always @(posedge i_clk) begin
      if (dut.u_props.err_count != 0)
         stop_on_failure("bound checker assertion failed");
   end

   // ####################
   // Stimulus.
   // ####################
   initial begin
      alu_pkg::alu_req_t req;
      int                gap [N];
      int                issued;
      int                cycles;
      i_clk       = 1'b0;
      i_nrst      = 1'b0;
      i_req_valid = '0;
      i_req       = '0;
      rng_state   = 32'd75879;
      issued      = 0;
      cycles      = 0;
      for (int k = 0; k < N; k++)
         gap[k] = 0;
      add_directed(alu_pkg::OP_ADD, W'(MAX_S), W'(1));
      add_directed(alu_pkg::OP_ADD, W'(MIN_S), W'(-1));
      add_directed(alu_pkg::OP_ADD, W'(MAX_S), W'(MIN_S));
      add_directed(alu_pkg::OP_SUB, W'(MIN_S), W'(1));
      add_directed(alu_pkg::OP_SUB, W'(MAX_S), W'(-1));
      add_directed(alu_pkg::OP_SUB, W'(0), W'(MIN_S));
      add_directed(alu_pkg::OP_SUB, W'(-1), W'(MAX_S));
      for (int s = 0; s < 4; s++) begin
         add_directed(alu_pkg::OP_MUL, W'(s[0] ? -7 : 7), W'(s[1] ? -9 : 9));
         add_directed(alu_pkg::OP_DIV, W'(s[0] ? -100 : 100), W'(s[1] ? -7 : 7));
      end
      add_directed(alu_pkg::OP_MUL, W'(MIN_S), W'(-1));
      add_directed(alu_pkg::OP_DIV, W'(MIN_S), W'(-1));
      add_directed(alu_pkg::OP_DIV, W'(5), W'(0));
      add_directed(alu_pkg::OP_DIV, W'(-5), W'(0));

      repeat (16) @(posedge i_clk);
      i_nrst <= 1'b1;
      repeat (4) @(posedge i_clk);                         // Quiet period.

      while (issued < NUM_REQS) begin
         @(posedge i_clk);
         cycles++;
         if (cycles > STIM_LIMIT)
            stop_on_failure("requests were not accepted in time");
         for (int k = 0; k < N; k++) begin
            if (gap[k] != 0 || issued >= NUM_REQS ||
                outstanding[k] + int'(i_req_valid[k]) >= DEPTH) begin
               i_req_valid[k] <= 1'b0;
               if (gap[k] != 0)
                  gap[k]--;
            end else begin
               next_request(req);
               i_req[k]       <= req;
               i_req_valid[k] <= 1'b1;
               issued++;
               rng_state = xorshift32(rng_state);
               gap[k]    = (rng_state[7:4] > 4'd11) ? int'(rng_state[2:0]) : 0;
            end
         end
      end
      @(posedge i_clk);
      i_req_valid <= '0;

      cycles = 0;
      while (!clients_idle()) begin
         @(posedge i_clk);
         cycles++;
         if (cycles > DRAIN_LIMIT)
            stop_on_failure("responses did not drain in time");
      end

      if (dut.u_props.err_count != 0) begin
         stop_on_failure("bound checker reported errors");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

// File: alu_pkg.sv
`include "alu_settings.svh"

package alu_pkg;

   // ####################
   // Operation codes.
   // ####################
   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_DIV = 2'd3
   } alu_op_e;

   typedef struct packed {
      alu_op_e                          op;
      logic signed [`ALU_DATA_WIDTH-1:0] a;
      logic signed [`ALU_DATA_WIDTH-1:0] b;
   } alu_req_t;

   typedef struct packed {
      logic signed [`ALU_DATA_WIDTH-1:0] q;
      logic                              ovf;    // Signed overflow of add or sub.
      logic                              zero;   // Divide by zero.
   } alu_rsp_t;

   typedef logic [$clog2(`ALU_NUM_CLIENTS)-1:0] client_id_t;

   // Request with the client that issued it.
   typedef struct packed {
      alu_req_t   req;
      client_id_t id;
   } alu_tag_req_t;

endpackage

// File: alu_req_fifo.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_req_fifo #(
   parameter type T     = alu_pkg::alu_req_t,
   parameter int  DEPTH = `ALU_FIFO_DEPTH
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_push,
   input  T     i_data,
   input  logic i_pop,
   output T     o_head,
   output logic o_empty,
   output logic o_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push = i_push & ~o_full;
   assign do_pop  = i_pop & ~o_empty;
   assign o_empty = (count == '0);
   assign o_full  = (count == CNT_W'(DEPTH));
   assign o_head  = mem[rd_ptr];

   always_ff @(posedge i_clk) begin
      if (do_push)
         mem[wr_ptr] <= i_data;
   end

   // ####################
   // Pointers and fill level.
   // ####################
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                        // Both or neither.
         endcase
      end
   end

endmodule

// File: alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// ####################
// Cluster sizing.
// ####################

// Operand and result width.
`define ALU_DATA_WIDTH  16
`define ALU_FIFO_DEPTH  4     // Entries per client queue.
`define ALU_NUM_CLIENTS 2     // Peer clients sharing the ALU.

`endif

// File: sequential_alu.sv
`timescale 1ns/1ps
`include "alu_settings.svh"

module sequential_alu #(
   parameter int DATA_WIDTH = `ALU_DATA_WIDTH
) (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_start,
   input  alu_pkg::alu_tag_req_t i_cmd,
   output logic                  o_busy,
   output logic                  o_done,
   output alu_pkg::alu_rsp_t     o_rsp,
   output alu_pkg::client_id_t   o_tag
);

   localparam int                    CNT_W = $clog2(DATA_WIDTH + 1);
   localparam int                    MSB   = DATA_WIDTH - 1;
   localparam logic [DATA_WIDTH-1:0] ONE   = DATA_WIDTH'(1);

   typedef enum logic [2:0] {
      SM_IDLE,
      SM_SIGN_B,
      SM_SIGN_Q,
      SM_MUL,
      SM_DIV_SHIFT,
      SM_DIV_CMP,
      SM_DIV_CNT
   } state_e;

   state_e                       state;
   state_e                       run_state;
   alu_pkg::alu_req_t            req;
   logic [DATA_WIDTH-1:0]        a;          // Multiplier or dividend magnitude.
   logic [DATA_WIDTH-1:0]        b;          // Multiplicand or divisor magnitude.
   logic [DATA_WIDTH-1:0]        r;          // Partial remainder.
   logic [DATA_WIDTH-1:0]        acc;        // Product or quotient.
   logic [CNT_W-1:0]             cnt;
   logic                         op_mul;
   logic                         neg;
   logic                         ovf;
   logic                         zero;
   logic                         a_neg;
   logic                         b_neg;
   logic                         is_mul;
   logic                         mul_last;
   logic                         carry;
   logic                         div_ge;
   logic signed [DATA_WIDTH-1:0] adder_a;
   logic signed [DATA_WIDTH-1:0] adder_b;
   logic signed [DATA_WIDTH-1:0] adder_q;
   logic                         adder_ovf;

   assign req       = i_cmd.req;
   assign a_neg     = req.a[MSB];
   assign b_neg     = req.b[MSB];
   assign is_mul    = (req.op == alu_pkg::OP_MUL);
   assign run_state = ((state == SM_IDLE) ? is_mul : op_mul) ? SM_MUL : SM_DIV_SHIFT;
   assign mul_last  = (a[DATA_WIDTH-1:1] == '0);

   // Carry out of ~r + b, set when r < b.
   assign carry  = (adder_a[MSB] & adder_b[MSB]) |
                   ((adder_a[MSB] | adder_b[MSB]) & ~adder_q[MSB]);
   assign div_ge = ~carry;

   assign o_rsp = '{q: acc, ovf: ovf, zero: zero};

   // ####################
   // Shared adder.
   // ####################
   always_comb begin
      adder_a = '0;
      adder_b = '0;
      case (state)
         SM_IDLE: begin
            case (req.op)
               alu_pkg::OP_ADD: begin
                  adder_a = req.a;
                  adder_b = req.b;
               end
               alu_pkg::OP_SUB: begin
                  adder_a = ~req.a;           // a - b is ~(~a + b).
                  adder_b = req.b;
               end
               default: begin
                  adder_a = a_neg ? ~req.a : ~req.b;
                  adder_b = ONE;
               end
            endcase
         end
         SM_SIGN_B: begin
            adder_a = ~b;
            adder_b = ONE;
         end
         SM_SIGN_Q: begin
            adder_a = ~acc;
            adder_b = ONE;
         end
         SM_MUL: begin
            adder_a = acc;
            adder_b = b;
         end
         SM_DIV_CMP: begin
            adder_a = ~r;                     // Difference is ~sum.
            adder_b = b;
         end
         SM_DIV_CNT: begin
            adder_a = DATA_WIDTH'(cnt);
            adder_b = ONE;
         end
         default: ;
      endcase
   end

   adder #(
      .DATA_WIDTH (DATA_WIDTH)
   ) u_adder (
      .i_a   (adder_a),
      .i_b   (adder_b),
      .o_q   (adder_q),
      .o_ovf (adder_ovf)
   );

   // ####################
   // Control.
   // ####################
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= SM_IDLE;
         o_busy <= 1'b0;
         o_done <= 1'b0;
         o_tag  <= '0;
         op_mul <= 1'b0;
         neg    <= 1'b0;
         ovf    <= 1'b0;
         zero   <= 1'b0;
         cnt    <= '0;
         acc    <= '0;
         a      <= '0;
         b      <= '0;
         r      <= '0;
      end else begin
         o_done <= 1'b0;
         if (o_done)
            o_busy <= 1'b0;
         case (state)
            SM_IDLE: begin
               if (i_start) begin
                  o_busy <= 1'b1;
                  o_tag  <= i_cmd.id;
                  op_mul <= is_mul;
                  neg    <= a_neg ^ b_neg;
                  ovf    <= 1'b0;
                  zero   <= 1'b0;
                  cnt    <= '0;
                  acc    <= '0;
                  r      <= '0;
                  a      <= req.a;
                  b      <= req.b;
                  if (req.op == alu_pkg::OP_ADD || req.op == alu_pkg::OP_SUB) begin
                     acc    <= (req.op == alu_pkg::OP_SUB) ? ~adder_q : adder_q;
                     ovf    <= adder_ovf;
                     o_done <= 1'b1;
                  end else if (!is_mul && req.b == '0) begin
                     zero   <= 1'b1;
                     o_done <= 1'b1;
                  end else begin
                     state <= (a_neg && b_neg) ? SM_SIGN_B : run_state;
                     if (a_neg)
                        a <= adder_q;
                     else if (b_neg)
                        b <= adder_q;
                  end
               end
            end
            SM_SIGN_B: begin
               b     <= adder_q;
               state <= run_state;
            end
            SM_SIGN_Q: begin
               acc    <= adder_q;
               o_done <= 1'b1;
               state  <= SM_IDLE;
            end
            SM_MUL: begin
               if (a[0])
                  acc <= adder_q;
               a <= a >> 1;
               b <= b << 1;
               if (mul_last) begin
                  o_done <= ~neg;
                  state  <= neg ? SM_SIGN_Q : SM_IDLE;
               end
            end
            SM_DIV_SHIFT: begin
               r     <= {r[DATA_WIDTH-2:0], a[MSB]};
               a     <= a << 1;
               state <= SM_DIV_CMP;
            end
            SM_DIV_CMP: begin
               if (div_ge)
                  r <= ~adder_q;
               acc   <= {acc[DATA_WIDTH-2:0], div_ge};
               state <= SM_DIV_CNT;
            end
            SM_DIV_CNT: begin
               cnt <= adder_q[CNT_W-1:0];
               if (adder_q == DATA_WIDTH'(DATA_WIDTH)) begin
                  o_done <= ~neg;
                  state  <= neg ? SM_SIGN_Q : SM_IDLE;
               end else begin
                  state <= SM_DIV_SHIFT;
               end
            end
            default: state <= SM_IDLE;
         endcase
      end
   end

endmodule
